//--- Makefile
SIM    := verilator
FLAGS  := --binary --timing -j 0
TOP    := psmem_tb
FLIST  := psmem.f
LOG    := sim.log
OBJ    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)

run: build
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

//--- logic/axil_read_port.sv
// AXI4-Lite read channel
// latches the read address, waits out the RAM read, holds the read data
module axil_read_port
    import psmem_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        ar_valid,
    input  logic [psmem_addr_bits-1:0]  ar_addr,
    input  logic                        r_ready,
    output logic                        ar_ready,
    output logic                        r_valid,
    output logic [psmem_data_bits-1:0]  r_data,
    output logic [1:0]                  r_resp,
    output ram_rd_t                     ram_rd,
    input  logic [psmem_data_bits-1:0]  rd_data
);

    // low from address accept until the data handshake
    logic idle;

    // stage flags, one per cycle of the read
    logic rd_en;
    logic capture;

    // word index decoded at accept
    logic [psmem_index_bits-1:0] rd_index;

    // edge 0: new address seen while idle
    logic accept;

    assign accept = idle && ar_valid;

    // accept -> read -> capture -> respond, one edge each
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            idle     <= 1'b1;
            ar_ready <= 1'b0;
            rd_en    <= 1'b0;
            capture  <= 1'b0;
            r_valid  <= 1'b0;
            r_data   <= '0;
        end
        else
        begin
            ar_ready <= accept;
            // address transfer completes here, fire the RAM read
            rd_en    <= ar_ready && ar_valid;
            // RAM output register loads at the end of this stage
            capture  <= rd_en;
            if (capture)
            begin
                r_data  <= rd_data;
                r_valid <= 1'b1;
            end
            else if (r_valid && r_ready)
            begin
                r_valid <= 1'b0;
            end
            if (accept)
            begin
                idle <= 1'b0;
            end
            else if (r_valid && r_ready)
            begin
                idle <= 1'b1;
            end
        end
    end

    // byte offset and bits above the index are dropped
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            rd_index <= ar_addr[psmem_addr_lsb +: psmem_index_bits];
        end
    end

    always_comb
    begin
        ram_rd.en    = rd_en;
        ram_rd.index = rd_index;
    end

    assign r_resp = resp_okay;

endmodule

//--- logic/axil_write_port.sv
// AXI4-Lite write channel
// joins address and data, writes the RAM and holds the write response
module axil_write_port
    import psmem_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        aw_valid,
    input  logic [psmem_addr_bits-1:0]  aw_addr,
    input  logic                        w_valid,
    input  logic [psmem_data_bits-1:0]  w_data,
    input  logic                        b_ready,
    output logic                        aw_ready,
    output logic                        w_ready,
    output logic                        b_valid,
    output logic [1:0]                  b_resp,
    output ram_wr_t                     ram_wr
);

    // low while a write is in flight, up to the end of its response
    logic idle;

    // edge 0: address and data both offered to an idle port
    logic accept;

    // edge 1: both transfers complete on this edge
    logic xfer;

    // word index decoded from the byte address
    logic [psmem_index_bits-1:0] wr_index;

    assign accept = idle && aw_valid && w_valid;
    assign xfer   = aw_ready && aw_valid && w_ready && w_valid;

    // ready pulses for one cycle, then the port stays busy
    // until the master takes the response
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            idle     <= 1'b1;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
        end
        else
        begin
            aw_ready <= accept;
            w_ready  <= accept;
            if (accept)
            begin
                idle <= 1'b0;
            end
            else if (b_valid && b_ready)
            begin
                idle <= 1'b1;
            end
        end
    end

    // drop byte offset, upper bits alias back into the array
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            wr_index <= aw_addr[psmem_addr_lsb +: psmem_index_bits];
        end
    end

    // response comes up on the same edge the RAM takes the word
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            b_valid <= 1'b0;
        end
        else if (xfer)
        begin
            b_valid <= 1'b1;
        end
        else if (b_ready)
        begin
            b_valid <= 1'b0;
        end
    end

    // wdata is still held by the master during the transfer cycle
    always_comb
    begin
        ram_wr.en    = xfer;
        ram_wr.index = wr_index;
        ram_wr.data  = w_data;
    end

    // no error cases in this memory
    assign b_resp = resp_okay;

endmodule

//--- logic/block_dual_port_ram.sv
// dual port block RAM
// one write port and one registered read port, read-before-write
module block_dual_port_ram
    import psmem_pkg::*;
(
    input  logic                        clk,
    input  ram_wr_t                     wr,
    input  ram_rd_t                     rd,
    output logic [psmem_data_bits-1:0]  rd_data
);

    logic [psmem_data_bits-1:0] mem [psmem_words];

    // write side
    always_ff @(posedge clk)
    begin
        if (wr.en)
        begin
            mem[wr.index] <= wr.data;
        end
    end

    // output register only moves on a read enable
    // same-index write on the same edge gives the old word
    always_ff @(posedge clk)
    begin
        if (rd.en)
        begin
            rd_data <= mem[rd.index];
        end
    end

endmodule

//--- logic/psmem_pkg.sv
// psmem shared definitions
// sizes, AXI4-Lite channel bundles and RAM port bundles
package psmem_pkg;

    // word width on the bus and in the RAM
    localparam int psmem_data_bits = 32;

    // RAM word index, 1024 words
    localparam int psmem_index_bits = 10;
    localparam int psmem_words = 1 << psmem_index_bits;

    // byte offset bits below the word index
    localparam int psmem_addr_lsb = 2;

    // full AXI byte address
    localparam int psmem_addr_bits = 16;

    // only response ever returned
    localparam logic [1:0] resp_okay = 2'b00;

    // everything the master drives
    typedef struct packed {
        logic                           awvalid;
        logic [psmem_addr_bits-1:0]     awaddr;
        logic                           wvalid;
        logic [psmem_data_bits-1:0]     wdata;
        // strobes are carried on the bus but every write is a full word
        logic [psmem_data_bits/8-1:0]   wstrb;
        logic                           bready;
        logic                           arvalid;
        logic [psmem_addr_bits-1:0]     araddr;
        logic                           rready;
    } axil_req_t;

    // everything the slave drives
    typedef struct packed {
        logic                           awready;
        logic                           wready;
        logic                           bvalid;
        logic [1:0]                     bresp;
        logic                           arready;
        logic                           rvalid;
        logic [psmem_data_bits-1:0]     rdata;
        logic [1:0]                     rresp;
    } axil_rsp_t;

    // one RAM write
    typedef struct packed {
        logic                           en;
        logic [psmem_index_bits-1:0]    index;
        logic [psmem_data_bits-1:0]     data;
    } ram_wr_t;

    // one RAM read request
    typedef struct packed {
        logic                           en;
        logic [psmem_index_bits-1:0]    index;
    } ram_rd_t;

endpackage

//--- logic/psmem_top.sv
// psmem top level
// AXI4-Lite write and read channels sharing one dual port RAM
module psmem_top
    import psmem_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  axil_req_t   req,
    output axil_rsp_t   rsp
);

    ram_wr_t                    ram_wr;
    ram_rd_t                    ram_rd;
    logic [psmem_data_bits-1:0] rd_data;

    // write channel owns awready, wready, bvalid and bresp
    axil_write_port i_axil_write_port (
        .clk      (clk),
        .rst      (rst),
        .aw_valid (req.awvalid),
        .aw_addr  (req.awaddr),
        .w_valid  (req.wvalid),
        .w_data   (req.wdata),
        .b_ready  (req.bready),
        .aw_ready (rsp.awready),
        .w_ready  (rsp.wready),
        .b_valid  (rsp.bvalid),
        .b_resp   (rsp.bresp),
        .ram_wr   (ram_wr)
    );

    // read channel owns the rest of the response bundle
    axil_read_port i_axil_read_port (
        .clk      (clk),
        .rst      (rst),
        .ar_valid (req.arvalid),
        .ar_addr  (req.araddr),
        .r_ready  (req.rready),
        .ar_ready (rsp.arready),
        .r_valid  (rsp.rvalid),
        .r_data   (rsp.rdata),
        .r_resp   (rsp.rresp),
        .ram_rd   (ram_rd),
        .rd_data  (rd_data)
    );

    block_dual_port_ram i_block_dual_port_ram (
        .clk     (clk),
        .wr      (ram_wr),
        .rd      (ram_rd),
        .rd_data (rd_data)
    );

endmodule

//--- psmem.f
logic/psmem_pkg.sv
logic/block_dual_port_ram.sv
logic/axil_write_port.sv
logic/axil_read_port.sv
logic/psmem_top.sv
test/psmem_tb.sv

//--- test/psmem_tb.sv
// psmem testbench
// drives the AXI4-Lite port and checks every response against a memory model
module psmem_tb
    import psmem_pkg::*;
;
    // transaction count sets the cycle limit
    localparam int n_trans = 64 + 64 + 2 + 2 * 8 + 7 + 200;
    localparam int cycle_limit = 40 * n_trans + 100;

    logic       clk = 1'b0;
    logic       rst;
    axil_req_t  req;
    axil_rsp_t  rsp;

    logic [31:0] lfsr;
    logic [psmem_data_bits-1:0] model [psmem_words];
    logic [psmem_data_bits-1:0] rd_expect [$];
    int cycles = 0;

    // held-data tracking for the comparing process
    logic r_hold = 1'b0;
    logic [psmem_data_bits-1:0] r_prev;

    psmem_top i_psmem_top (
        .clk (clk),
        .rst (rst),
        .req (req),
        .rsp (rsp)
    );

    always #10 clk = ~clk;

    // Galois LFSR, x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // one step per bit taken
    task automatic get_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // word number of a byte address, wrapping past the top of memory
    function automatic int word_index(input logic [15:0] addr);
        return (int'(addr) >> psmem_addr_lsb) % psmem_words;
    endfunction

    // expected word for a byte address
    function automatic logic [psmem_data_bits-1:0] ref_read(input logic [15:0] addr);
        return model[word_index(addr)];
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s: got %h expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_idle();
        check_value(rsp.awready, 0, "awready in reset");
        check_value(rsp.wready, 0, "wready in reset");
        check_value(rsp.bvalid, 0, "bvalid in reset");
        check_value(rsp.arready, 0, "arready in reset");
        check_value(rsp.rvalid, 0, "rvalid in reset");
    endtask

    // one write; during back-pressure the same write is offered again
    task automatic do_write(input logic [15:0] addr, input logic [31:0] data,
                            input int bp, input bit check_lat);
        int n;
        int pass_cnt;
        pass_cnt = (bp > 0) ? 2 : 1;
        @(posedge clk);
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= '1;
        req.bready  <= (bp == 0);
        model[word_index(addr)] = data;
        for (int p = 0; p < pass_cnt; p++)
        begin
            n = 0;
            do
            begin
                @(posedge clk);
                n++;
                if (rsp.awready)
                begin
                    req.awvalid <= 1'b0;
                    req.wvalid  <= 1'b0;
                end
            end
            while (!rsp.bvalid);
            if (check_lat && p == 0)
                check_value(n - 1, 2, "write latency");
            if (p == 0 && bp > 0)
            begin
                req.awvalid <= 1'b1;
                req.wvalid  <= 1'b1;
                for (int k = 0; k < bp; k++)
                begin
                    @(posedge clk);
                    check_value(rsp.bvalid, 1, "bvalid held");
                    check_value(rsp.awready | rsp.wready, 0, "write ready while busy");
                end
                req.bready <= 1'b1;
                @(posedge clk);
            end
        end
        req.bready <= 1'b0;
    endtask

    // one read; during back-pressure the same read is offered again
    task automatic do_read(input logic [15:0] addr, input int bp, input bit check_lat);
        int n;
        int pass_cnt;
        pass_cnt = (bp > 0) ? 2 : 1;
        @(posedge clk);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        req.rready  <= (bp == 0);
        rd_expect.push_back(ref_read(addr));
        for (int p = 0; p < pass_cnt; p++)
        begin
            n = 0;
            do
            begin
                @(posedge clk);
                n++;
                if (rsp.arready)
                    req.arvalid <= 1'b0;
            end
            while (!rsp.rvalid);
            if (check_lat && p == 0)
                check_value(n - 1, 4, "read latency");
            if (p == 0 && bp > 0)
            begin
                req.arvalid <= 1'b1;
                rd_expect.push_back(ref_read(addr));
                for (int k = 0; k < bp; k++)
                begin
                    @(posedge clk);
                    check_value(rsp.rvalid, 1, "rvalid held");
                    check_value(rsp.arready, 0, "arready while busy");
                end
                req.rready <= 1'b1;
                @(posedge clk);
            end
        end
        req.rready <= 1'b0;
    endtask

    // comparing process, responses checked at their completing edge
    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (rsp.bvalid && req.bready)
                check_value(rsp.bresp, 2'b00, "bresp");
            if (r_hold)
                check_value(rsp.rdata, r_prev, "rdata stable");
            if (rsp.rvalid && req.rready)
            begin
                if (rd_expect.size() == 0)
                begin
                    $display("read data came back with no read outstanding");
                    $display("TESTS FAILED");
                    $fatal(1);
                end
                check_value(rsp.rdata, rd_expect.pop_front(), "rdata");
                check_value(rsp.rresp, 2'b00, "rresp");
            end
            r_hold = rsp.rvalid && !req.rready;
            r_prev = rsp.rdata;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: the run went past %0d cycles", cycle_limit);
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] d;
        req  = '0;
        rst  = 1'b1;
        lfsr = 32'h3304_0a01;
        @(posedge clk);
        repeat (2)
        begin
            @(posedge clk);
            check_idle();
        end
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        check_idle();

        // fill the low 64 words, then read them back
        for (int i = 0; i < 64; i++)
        begin
            get_bits(32, d);
            do_write(16'(i << psmem_addr_lsb), d, 0, 0);
        end
        for (int i = 0; i < 64; i++)
            do_read(16'(i << psmem_addr_lsb), 0, 0);

        // latency with ready held high
        do_write(16'h0100, 32'hcafe_0001, 0, 1);
        do_read(16'h0100, 0, 1);

        // back-pressure, random 0 to 7 cycles
        for (int i = 0; i < 8; i++)
        begin
            get_bits(3, r);
            get_bits(32, d);
            do_write(16'(i << psmem_addr_lsb), d, r, 0);
            get_bits(3, r);
            do_read(16'(i << psmem_addr_lsb), r, 0);
        end

        // low byte bits and bits above the index alias to the same word
        do_write(16'h0203, 32'h1234_5678, 0, 0);
        do_read(16'h0200, 0, 0);
        do_read(16'h3201, 0, 0);
        do_read(16'hf202, 0, 0);
        do_write(16'h5044, 32'h0bad_f00d, 0, 0);
        do_read(16'h0047, 0, 0);
        do_read(16'ha044, 0, 0);

        // 200 overlapping transactions, writes above word 64, reads below
        fork
            for (int i = 0; i < 100; i++)
            begin
                get_bits(2, r);
                repeat (r) @(posedge clk);
                get_bits(6, r);
                get_bits(32, d);
                d[31:16] = d[15:0] ^ 16'h5a5a;
                do_write({4'(d[19:16]), 4'd0, 8'd0} | 16'((64 + r) << 2), d, d[2:0], 0);
            end
            for (int i = 0; i < 100; i++)
            begin
                get_bits(2, r);
                repeat (r) @(posedge clk);
                get_bits(12, r);
                get_bits(3, d);
                do_read({r[11:8], 4'd0, 8'd0} | 16'(r[5:0] << 2) | 16'(r[7:6]), d, 0);
            end
        join

        repeat (4) @(posedge clk);
        if (rd_expect.size() != 0)
        begin
            $display("reads were left without data at the end of the run");
            $display("TESTS FAILED");
            $fatal(1);
        end
        else
        begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule
